// ==== axi_pkg.sv ====
package axi_pkg;

    // read channel field widths
    localparam int axi_id_w = 4;
    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 64;
    localparam int axi_len_w = 8;
    localparam int axi_size_w = 3;
    localparam int axi_burst_w = 2;
    localparam int axi_resp_w = 2;

    // one outstanding burst per id
    localparam int axi_outstanding = 2 ** axi_id_w;

    localparam logic [axi_burst_w-1:0] axi_burst_incr = 2'b01;

    localparam logic [axi_resp_w-1:0] axi_resp_okay = 2'b00;

endpackage

// ==== lsu_pkg.sv ====
package lsu_pkg;

    localparam int apb_addr_w = 16;
    localparam int apb_data_w = 32;

    // register offsets
    localparam logic [apb_addr_w-1:0] reg_dram_addr = 16'h0000;
    localparam logic [apb_addr_w-1:0] reg_sram_addr = 16'h0004;
    localparam logic [apb_addr_w-1:0] reg_cfg = 16'h0008;
    localparam logic [apb_addr_w-1:0] reg_ctrl = 16'h000C;
    localparam logic [apb_addr_w-1:0] reg_status = 16'h0010;

    // scratchpad readback, two 32-bit halves per word
    localparam logic [apb_addr_w-1:0] sram_window_base = 16'h0800;

    localparam int sram_addr_w = 12;
    localparam int sram_depth = 4096;
    localparam int sram_data_w = 64;

    localparam int cmd_len_w = 8;
    localparam int cmd_size_w = 3;
    localparam int cmd_num_w = 8;

    // reg_cfg field positions
    localparam int cfg_len_lsb = 0;
    localparam int cfg_size_lsb = 8;
    localparam int cfg_num_lsb = 16;

    localparam int ctrl_start_bit = 0;

    localparam int stat_busy_bit = 0;
    localparam int stat_done_bit = 1;
    localparam int stat_error_bit = 2;

endpackage

// ==== lsu_ifs.sv ====
interface lsu_cmd_if;

    logic start;
    logic [axi_pkg::axi_addr_w-1:0] dram_addr;
    logic [lsu_pkg::sram_addr_w-1:0] sram_addr;
    logic [lsu_pkg::cmd_len_w-1:0] arlen;
    logic [lsu_pkg::cmd_size_w-1:0] arsize;
    logic [lsu_pkg::cmd_num_w-1:0] arnum;
    logic idle;

    modport regs (
        output start, dram_addr, sram_addr, arlen, arsize, arnum,
        input idle
    );
    modport master (
        input start, dram_addr, sram_addr, arlen, arsize, arnum,
        output idle
    );
    modport fill (
        input start, arnum
    );

endinterface

interface lsu_resp_if;

    logic valid;
    logic [axi_pkg::axi_data_w-1:0] data;
    logic [axi_pkg::axi_resp_w-1:0] resp;
    logic last;
    logic [axi_pkg::axi_id_w-1:0] id;
    logic ready;

    modport src (output valid, data, resp, last, id, input ready);
    modport sink (input valid, data, resp, last, id, output ready);

endinterface

// ==== lsu_cmd_regs.sv ====
module lsu_cmd_regs (
    input  logic clk,
    input  logic reset,
    input  logic [lsu_pkg::apb_addr_w-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [lsu_pkg::apb_data_w-1:0] pwdata,
    output logic [lsu_pkg::apb_data_w-1:0] prdata,
    output logic pready,
    output logic pslverr,
    lsu_cmd_if.regs cmd,
    input  logic done,
    input  logic error,
    output logic sram_rd_en,
    output logic [lsu_pkg::sram_addr_w-1:0] sram_rd_addr,
    input  logic [lsu_pkg::sram_data_w-1:0] sram_rd_data
);

    logic [lsu_pkg::apb_addr_w-1:0] win_off;
    logic win_hit;
    logic reg_hit;
    logic wr_en;
    logic busy_q;
    logic busy;
    logic [lsu_pkg::apb_data_w-1:0] reg_rdata;

    // window covers 4096 words, so offset bit 15 must be clear
    assign win_off = paddr - lsu_pkg::sram_window_base;
    assign win_hit = (paddr >= lsu_pkg::sram_window_base) && !win_off[lsu_pkg::apb_addr_w-1];
    assign sram_rd_addr = win_off[lsu_pkg::sram_addr_w+2:3];

    // array read launched from the setup phase address
    assign sram_rd_en = psel & ~penable & ~pwrite & win_hit;

    assign wr_en = psel & penable & pwrite;

    // done being set already ends the job for a new start
    assign busy = (busy_q & ~done) | ~cmd.idle;

    assign cmd.start = wr_en & (paddr == lsu_pkg::reg_ctrl)
                     & pwdata[lsu_pkg::ctrl_start_bit] & ~busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
        end else if (cmd.start) begin
            busy_q <= 1'b1;
        end else if (done) begin
            busy_q <= 1'b0;
        end
    end

    // job registers are frozen while a job runs
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd.dram_addr <= '0;
            cmd.sram_addr <= '0;
            cmd.arlen <= '0;
            cmd.arsize <= '0;
            cmd.arnum <= '0;
        end else if (wr_en && !busy) begin
            case (paddr)
                lsu_pkg::reg_dram_addr: cmd.dram_addr <= pwdata;
                lsu_pkg::reg_sram_addr: cmd.sram_addr <= pwdata[lsu_pkg::sram_addr_w-1:0];
                lsu_pkg::reg_cfg: begin
                    cmd.arlen <= pwdata[lsu_pkg::cfg_len_lsb +: lsu_pkg::cmd_len_w];
                    cmd.arsize <= pwdata[lsu_pkg::cfg_size_lsb +: lsu_pkg::cmd_size_w];
                    cmd.arnum <= pwdata[lsu_pkg::cfg_num_lsb +: lsu_pkg::cmd_num_w];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        reg_rdata = '0;
        reg_hit = 1'b1;
        case (paddr)
            lsu_pkg::reg_dram_addr: reg_rdata = cmd.dram_addr;
            lsu_pkg::reg_sram_addr: reg_rdata[lsu_pkg::sram_addr_w-1:0] = cmd.sram_addr;
            lsu_pkg::reg_cfg: begin
                reg_rdata[lsu_pkg::cfg_len_lsb +: lsu_pkg::cmd_len_w] = cmd.arlen;
                reg_rdata[lsu_pkg::cfg_size_lsb +: lsu_pkg::cmd_size_w] = cmd.arsize;
                reg_rdata[lsu_pkg::cfg_num_lsb +: lsu_pkg::cmd_num_w] = cmd.arnum;
            end
            lsu_pkg::reg_ctrl: reg_rdata = '0;
            lsu_pkg::reg_status: begin
                reg_rdata[lsu_pkg::stat_busy_bit] = busy;
                reg_rdata[lsu_pkg::stat_done_bit] = done;
                reg_rdata[lsu_pkg::stat_error_bit] = error;
            end
            default: reg_hit = 1'b0;
        endcase
    end

    // address bit 2 picks the upper half of the word
    assign prdata = !win_hit ? reg_rdata
                  : paddr[2] ? sram_rd_data[lsu_pkg::apb_data_w +: lsu_pkg::apb_data_w]
                  : sram_rd_data[0 +: lsu_pkg::apb_data_w];

    assign pready = 1'b1;
    assign pslverr = psel & penable & ~(reg_hit | win_hit);

endmodule

// ==== axi_read_intf.sv ====
module axi_read_intf (
    input  logic clk,
    input  logic reset,
    lsu_cmd_if.master cmd,
    // read address channel
    output logic [axi_pkg::axi_id_w-1:0] arid,
    output logic [axi_pkg::axi_addr_w-1:0] araddr,
    output logic [axi_pkg::axi_len_w-1:0] arlen,
    output logic [axi_pkg::axi_size_w-1:0] arsize,
    output logic [axi_pkg::axi_burst_w-1:0] arburst,
    output logic arvalid,
    input  logic arready,
    // read data channel
    input  logic [axi_pkg::axi_id_w-1:0] rid,
    input  logic [axi_pkg::axi_data_w-1:0] rdata,
    input  logic [axi_pkg::axi_resp_w-1:0] rresp,
    input  logic rlast,
    input  logic rvalid,
    output logic rready,
    lsu_resp_if.src resp,
    output logic alloc,
    output logic [axi_pkg::axi_id_w-1:0] alloc_id,
    output logic [lsu_pkg::sram_addr_w-1:0] alloc_sram
);

    logic [axi_pkg::axi_outstanding-1:0] slot_valid;
    logic [axi_pkg::axi_id_w-1:0] next_id;
    logic [lsu_pkg::cmd_num_w-1:0] burst_cnt;
    logic issuing;
    logic last_burst;

    logic [axi_pkg::axi_addr_w-1:0] next_dram;
    logic [lsu_pkg::sram_addr_w-1:0] next_sram;
    logic [axi_pkg::axi_addr_w-1:0] burst_beats;
    logic [axi_pkg::axi_addr_w-1:0] burst_bytes;
    logic [lsu_pkg::sram_addr_w-1:0] sram_step;

    logic r_take;
    logic last_done;

    // beats per burst, and the byte span of one burst
    assign burst_beats = {{(axi_pkg::axi_addr_w - lsu_pkg::cmd_len_w){1'b0}}, cmd.arlen} + 1'b1;
    assign burst_bytes = burst_beats << cmd.arsize;
    assign sram_step = {{(lsu_pkg::sram_addr_w - lsu_pkg::cmd_len_w){1'b0}}, cmd.arlen} + 1'b1;

    assign arid = next_id;
    assign araddr = next_dram;
    assign arlen = cmd.arlen;
    assign arsize = cmd.arsize;
    assign arburst = axi_pkg::axi_burst_incr;

    // stall AR until the next id in rotation has retired
    assign arvalid = issuing & ~slot_valid[next_id];

    assign alloc = arvalid & arready;
    assign alloc_id = next_id;
    assign alloc_sram = next_sram;

    assign last_burst = (burst_cnt == cmd.arnum);
    assign cmd.idle = ~|slot_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            issuing <= 1'b0;
            next_id <= '0;
            burst_cnt <= '0;
        end else if (cmd.start) begin
            issuing <= 1'b1;
            burst_cnt <= '0;
        end else if (alloc) begin
            next_id <= next_id + 1'b1;
            burst_cnt <= burst_cnt + 1'b1;
            if (last_burst) begin
                issuing <= 1'b0;
            end
        end
    end

    // address generator, one step per AR handshake
    always_ff @(posedge clk) begin
        if (cmd.start) begin
            next_dram <= cmd.dram_addr;
            next_sram <= cmd.sram_addr;
        end else if (alloc) begin
            next_dram <= next_dram + burst_bytes;
            next_sram <= next_sram + sram_step;
        end
    end

    // slot retires once the fill side takes its last beat
    assign last_done = resp.valid & resp.ready & resp.last;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= '0;
        end else begin
            if (last_done) begin
                slot_valid[resp.id] <= 1'b0;
            end
            if (alloc) begin
                slot_valid[next_id] <= 1'b1;
            end
        end
    end

    // single R holding register
    assign rready = ~resp.valid | resp.ready;
    assign r_take = rvalid & rready;

    always_ff @(posedge clk) begin
        if (reset) begin
            resp.valid <= 1'b0;
        end else if (r_take) begin
            resp.valid <= 1'b1;
        end else if (resp.ready) begin
            resp.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (r_take) begin
            resp.data <= rdata;
            resp.resp <= rresp;
            resp.last <= rlast;
            resp.id <= rid;
        end
    end

endmodule

// ==== sram_fill.sv ====
module sram_fill (
    input  logic clk,
    input  logic reset,
    lsu_cmd_if.fill cmd,
    lsu_resp_if.sink resp,
    input  logic alloc,
    input  logic [axi_pkg::axi_id_w-1:0] alloc_id,
    input  logic [lsu_pkg::sram_addr_w-1:0] alloc_sram,
    input  logic rd_en,
    input  logic [lsu_pkg::sram_addr_w-1:0] rd_addr,
    output logic [lsu_pkg::sram_data_w-1:0] rd_data,
    output logic done,
    output logic error
);

    logic [lsu_pkg::sram_addr_w-1:0] base_tbl [axi_pkg::axi_outstanding];
    logic [lsu_pkg::cmd_len_w-1:0] beat_off [axi_pkg::axi_outstanding];
    logic [lsu_pkg::sram_data_w-1:0] mem [lsu_pkg::sram_depth];

    logic wr_en;
    logic [lsu_pkg::sram_addr_w-1:0] wr_addr;
    logic [lsu_pkg::cmd_num_w-1:0] burst_cnt;

    // one port, so a window read blocks the beat for a cycle
    assign resp.ready = ~rd_en;
    assign wr_en = resp.valid & resp.ready;

    assign wr_addr = base_tbl[resp.id]
                   + {{(lsu_pkg::sram_addr_w - lsu_pkg::cmd_len_w){1'b0}}, beat_off[resp.id]};

    // per id base and beat offset
    always_ff @(posedge clk) begin
        if (alloc) begin
            base_tbl[alloc_id] <= alloc_sram;
            beat_off[alloc_id] <= '0;
        end
        if (wr_en) begin
            beat_off[resp.id] <= beat_off[resp.id] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= resp.data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
            error <= 1'b0;
            burst_cnt <= '0;
        end else if (cmd.start) begin
            done <= 1'b0;
            error <= 1'b0;
            burst_cnt <= '0;
        end else if (wr_en) begin
            if (resp.resp != axi_pkg::axi_resp_okay) begin
                error <= 1'b1;
            end
            if (resp.last) begin
                burst_cnt <= burst_cnt + 1'b1;
                // final burst of arnum+1
                if (burst_cnt == cmd.arnum) begin
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== lsu_dma_top.sv ====
module lsu_dma_top (
    input  logic clk,
    input  logic reset,
    // apb slave
    input  logic [lsu_pkg::apb_addr_w-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [lsu_pkg::apb_data_w-1:0] pwdata,
    output logic [lsu_pkg::apb_data_w-1:0] prdata,
    output logic pready,
    output logic pslverr,
    // axi read master
    output logic [axi_pkg::axi_id_w-1:0] arid,
    output logic [axi_pkg::axi_addr_w-1:0] araddr,
    output logic [axi_pkg::axi_len_w-1:0] arlen,
    output logic [axi_pkg::axi_size_w-1:0] arsize,
    output logic [axi_pkg::axi_burst_w-1:0] arburst,
    output logic arvalid,
    input  logic arready,
    input  logic [axi_pkg::axi_id_w-1:0] rid,
    input  logic [axi_pkg::axi_data_w-1:0] rdata,
    input  logic [axi_pkg::axi_resp_w-1:0] rresp,
    input  logic rlast,
    input  logic rvalid,
    output logic rready
);

    lsu_cmd_if cmd_if ();
    lsu_resp_if resp_if ();

    logic alloc;
    logic [axi_pkg::axi_id_w-1:0] alloc_id;
    logic [lsu_pkg::sram_addr_w-1:0] alloc_sram;
    logic done;
    logic error;
    logic sram_rd_en;
    logic [lsu_pkg::sram_addr_w-1:0] sram_rd_addr;
    logic [lsu_pkg::sram_data_w-1:0] sram_rd_data;

    lsu_cmd_regs lsu_cmd_regs_i (
        .clk(clk),
        .reset(reset),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .cmd(cmd_if.regs),
        .done(done),
        .error(error),
        .sram_rd_en(sram_rd_en),
        .sram_rd_addr(sram_rd_addr),
        .sram_rd_data(sram_rd_data)
    );

    axi_read_intf axi_read_intf_i (
        .clk(clk),
        .reset(reset),
        .cmd(cmd_if.master),
        .arid(arid),
        .araddr(araddr),
        .arlen(arlen),
        .arsize(arsize),
        .arburst(arburst),
        .arvalid(arvalid),
        .arready(arready),
        .rid(rid),
        .rdata(rdata),
        .rresp(rresp),
        .rlast(rlast),
        .rvalid(rvalid),
        .rready(rready),
        .resp(resp_if.src),
        .alloc(alloc),
        .alloc_id(alloc_id),
        .alloc_sram(alloc_sram)
    );

    sram_fill sram_fill_i (
        .clk(clk),
        .reset(reset),
        .cmd(cmd_if.fill),
        .resp(resp_if.sink),
        .alloc(alloc),
        .alloc_id(alloc_id),
        .alloc_sram(alloc_sram),
        .rd_en(sram_rd_en),
        .rd_addr(sram_rd_addr),
        .rd_data(sram_rd_data),
        .done(done),
        .error(error)
    );

endmodule

// ==== tb_lsu_dma.sv ====
module tb_lsu_dma;

    localparam int max_jobs = 32;
    localparam int clk_period = 100;
    localparam logic [1:0] resp_slverr = 2'b10;

    logic clk;
    logic reset;
    logic [lsu_pkg::apb_addr_w-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [lsu_pkg::apb_data_w-1:0] pwdata;
    logic [lsu_pkg::apb_data_w-1:0] prdata;
    logic pready;
    logic pslverr;
    logic [axi_pkg::axi_id_w-1:0] arid;
    logic [axi_pkg::axi_addr_w-1:0] araddr;
    logic [axi_pkg::axi_len_w-1:0] arlen;
    logic [axi_pkg::axi_size_w-1:0] arsize;
    logic [axi_pkg::axi_burst_w-1:0] arburst;
    logic arvalid;
    logic arready;
    logic [axi_pkg::axi_id_w-1:0] rid;
    logic [axi_pkg::axi_data_w-1:0] rdata;
    logic [axi_pkg::axi_resp_w-1:0] rresp;
    logic rlast;
    logic rvalid;
    logic rready;

    // job table
    int num_jobs;
    bit jobs_loaded = 1'b0;
    logic [31:0] job_dram [max_jobs];
    logic [11:0] job_sram [max_jobs];
    logic [7:0] job_len [max_jobs];
    logic [2:0] job_size [max_jobs];
    logic [7:0] job_num [max_jobs];
    logic job_err [max_jobs];
    logic [11:0] job_off [max_jobs][3];
    logic [63:0] job_data [max_jobs][3];

    // slave model state with one pending burst per id
    integer seed = 32'hf1d0_886e;
    logic pend_valid [axi_pkg::axi_outstanding];
    logic [31:0] pend_addr [axi_pkg::axi_outstanding];
    logic [7:0] pend_len [axi_pkg::axi_outstanding];
    logic [2:0] pend_size [axi_pkg::axi_outstanding];
    logic [7:0] pend_beat [axi_pkg::axi_outstanding];
    int pend_q [$];
    int outstanding;

    lsu_dma_top lsu_dma_top_i (
        .clk(clk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
        .arburst(arburst), .arvalid(arvalid), .arready(arready),
        .rid(rid), .rdata(rdata), .rresp(rresp), .rlast(rlast),
        .rvalid(rvalid), .rready(rready)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_values(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("error: %s expected %0h actual %0h",
                                        name, expected, actual));
        end
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge clk);
        paddr <= addr;
        pwdata <= data;
        pwrite <= 1'b1;
        psel <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [31:0] data);
        @(posedge clk);
        paddr <= addr;
        pwrite <= 1'b0;
        psel <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        // access phase sampled mid cycle
        @(negedge clk);
        data = prdata;
        compare_values($sformatf("pready at %0h", addr), 64'd1, 64'(pready));
        compare_values($sformatf("pslverr at %0h", addr), 64'd0, 64'(pslverr));
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_word(input logic [11:0] word, output logic [63:0] data);
        logic [31:0] lo;
        logic [31:0] hi;
        logic [15:0] base;
        base = lsu_pkg::sram_window_base + {1'b0, word, 3'b000};
        apb_read(base, lo);
        apb_read(base + 16'd4, hi);
        data = {hi, lo};
    endtask

    task automatic load_jobs();
        int fd;
        int n;
        string line;
        logic [63:0] v [12];
        num_jobs = 0;
        fd = $fopen("tb_input.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open tb_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                        v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
            if (n != 12 || num_jobs >= max_jobs) begin
                stop_with_failure("tb_input.txt has a malformed line or too many jobs");
            end
            job_dram[num_jobs] = v[0][31:0];
            job_sram[num_jobs] = v[1][11:0];
            job_len[num_jobs] = v[2][7:0];
            job_size[num_jobs] = v[3][2:0];
            job_num[num_jobs] = v[4][7:0];
            job_err[num_jobs] = v[5][0];
            for (int s = 0; s < 3; s++) begin
                job_off[num_jobs][s] = v[6 + 2 * s][11:0];
                job_data[num_jobs][s] = v[7 + 2 * s];
            end
            num_jobs++;
        end
        $fclose(fd);
        if (num_jobs == 0) begin
            stop_with_failure("tb_input.txt holds no jobs");
        end
    endtask

    task automatic run_job(input int j);
        logic [31:0] rd;
        logic [31:0] cfg;
        logic [63:0] word;
        cfg = {8'h00, job_num[j], 5'b00000, job_size[j], job_len[j]};
        apb_write(lsu_pkg::reg_dram_addr, job_dram[j]);
        apb_write(lsu_pkg::reg_sram_addr, {20'h0, job_sram[j]});
        apb_write(lsu_pkg::reg_cfg, cfg);
        apb_read(lsu_pkg::reg_dram_addr, rd);
        compare_values($sformatf("job %0d dram_addr readback", j), 64'(job_dram[j]), 64'(rd));
        apb_read(lsu_pkg::reg_sram_addr, rd);
        compare_values($sformatf("job %0d sram_addr readback", j), 64'(job_sram[j]), 64'(rd));
        apb_read(lsu_pkg::reg_cfg, rd);
        compare_values($sformatf("job %0d cfg readback", j), 64'(cfg), 64'(rd));
        apb_write(lsu_pkg::reg_ctrl, 32'h1);
        // window reads between polls steal array cycles from the fill side
        do begin
            read_word(job_sram[j] + job_off[j][0], word);
            apb_read(lsu_pkg::reg_status, rd);
        end while (!rd[lsu_pkg::stat_done_bit]);
        compare_values($sformatf("job %0d status", j), {61'd0, job_err[j], 2'b10}, 64'(rd));
        compare_values($sformatf("job %0d bursts left at slave", j), 64'd0, 64'(pend_q.size()));
        for (int s = 0; s < 3; s++) begin
            read_word(job_sram[j] + job_off[j][s], word);
            compare_values($sformatf("job %0d word offset %0h", j, job_off[j][s]),
                           job_data[j][s], word);
        end
    endtask

    initial begin : main_flow
        logic [31:0] rd;
        reset = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        load_jobs();
        jobs_loaded = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_values("arvalid after reset", 64'd0, 64'(arvalid));
        compare_values("rready after reset", 64'd1, 64'(rready));
        apb_read(lsu_pkg::reg_status, rd);
        compare_values("status after reset", 64'd0, 64'(rd));
        for (int j = 0; j < num_jobs; j++) begin
            run_job(j);
        end
        $display("Simulation passed");
        $finish;
    end

    // AXI read slave answering pending bursts in random order
    initial begin : axi_slave
        int unsigned pick;
        int del_idx;
        int id;
        logic [31:0] beat_addr;
        arready = 1'b0;
        rvalid = 1'b0;
        rid = '0;
        rdata = '0;
        rresp = '0;
        rlast = 1'b0;
        outstanding = 0;
        foreach (pend_valid[i]) begin
            pend_valid[i] = 1'b0;
        end
        forever begin
            @(posedge clk);
            if (!reset) begin
                arready <= ($random(seed) & 7) != 0;
                if (arvalid && arready) begin
                    outstanding++;
                    if (outstanding > axi_pkg::axi_outstanding) begin
                        stop_with_failure("more than 16 bursts outstanding on AXI");
                    end
                    if (pend_valid[arid]) begin
                        stop_with_failure("AR reused an id whose burst is still outstanding");
                    end
                    compare_values("arburst", 64'(axi_pkg::axi_burst_incr), 64'(arburst));
                    pend_valid[arid] = 1'b1;
                    pend_addr[arid] = araddr;
                    pend_len[arid] = arlen;
                    pend_size[arid] = arsize;
                    pend_beat[arid] = '0;
                    pend_q.push_back(int'(arid));
                end
                if (rvalid && rready) begin
                    if (rlast) begin
                        pend_valid[rid] = 1'b0;
                        del_idx = 0;
                        foreach (pend_q[i]) begin
                            if (pend_q[i] == int'(rid)) begin
                                del_idx = i;
                            end
                        end
                        pend_q.delete(del_idx);
                        outstanding--;
                    end else begin
                        pend_beat[rid] = pend_beat[rid] + 8'd1;
                    end
                end
                // hold a beat that was not taken
                if (!(rvalid && !rready)) begin
                    if (pend_q.size() == 0 || ($random(seed) & 3) == 0) begin
                        rvalid <= 1'b0;
                    end else begin
                        pick = $random(seed);
                        id = pend_q[pick % pend_q.size()];
                        beat_addr = pend_addr[id] + (32'(pend_beat[id]) << pend_size[id]);
                        rid <= id[axi_pkg::axi_id_w-1:0];
                        rdata <= {beat_addr, ~beat_addr};
                        rresp <= (beat_addr >= 32'hF000_0000) ? resp_slverr
                                                               : axi_pkg::axi_resp_okay;
                        rlast <= (pend_beat[id] == pend_len[id]);
                        rvalid <= 1'b1;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        longint cycles;
        wait (jobs_loaded);
        cycles = 2000;
        for (int j = 0; j < num_jobs; j++) begin
            cycles += (longint'(job_num[j]) + 1) * (longint'(job_len[j]) + 1) * 20;
        end
        #(cycles * clk_period);
        stop_with_failure("timeout: the engine never signalled done");
    end

endmodule

// ==== tb_input.txt ====
# dram sram arlen arsize arnum error, then three pairs of word offset and expected data
# all hex, word offsets count from the sram base of the job
10000000 000 07 3 00 0 000 10000000efffffff 003 10000018efffffe7 007 10000038efffffc7
20000100 100 03 3 27 0 000 20000100dffffeff 045 20000328dffffcd7 09f 200005f8dffffa07
30000040 400 0f 2 13 0 001 30000044cfffffbb 050 30000180cffffe7f 13f 3000053ccffffac3
efffffe0 800 03 3 03 1 000 efffffe01000001f 004 f00000000fffffff 00f f00000580fffffa7
00008000 a00 01 3 1f 0 000 00008000ffff7fff 021 00008108ffff7ef7 03f 000081f8ffff7e07
40000000 f00 00 3 40 0 000 40000000bfffffff 020 40000100bffffeff 040 40000200bffffdff

// ==== sources.f ====
axi_pkg.sv
lsu_pkg.sv
lsu_ifs.sv
lsu_cmd_regs.sv
axi_read_intf.sv
sram_fill.sv
lsu_dma_top.sv
tb_lsu_dma.sv

// ==== Makefile ====
TOP ?= tb_lsu_dma
SEED ?= 1
LOG ?= sim.log
VERILATOR ?= verilator
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal

SRCS := $(shell cat sources.f)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): sources.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sources.f

run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
